// ==== src/soc_config.svh ====
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// ----------------------------------------
// Memory map of the system bus
// ----------------------------------------

// Internal RAM covers everything from its base to the top of the map and echoes
`define SOC_RAM_BASE        32'hFFFF_0000
`define SOC_RAM_WORDS       2048

`define SOC_GPIO_BASE       32'h0300_0000
`define SOC_GPIO_LIMIT      32'h0300_0100   // Exclusive

`define SOC_UART_ADDR       32'h0300_0100   // Single word

// Shared byte RAM window, data kept in the low byte only
`define SOC_SHRAM_BASE      32'h0500_0000
`define SOC_SHRAM_LIMIT     32'h0504_0000   // Exclusive
`define SOC_SHRAM_WORDS     2048

// ----------------------------------------
// Peripheral timing and defaults
// ----------------------------------------

`define SOC_UART_BIT_CYCLES 4               // Clocks per serial bit

// Returned for an access that hits no region
`define SOC_UNMAPPED_RDATA  32'hFFFF_FFFF

`endif

// ==== src/soc_pkg.sv ====
package soc_pkg;

    // ----------------------------------------
    // Bus payload types
    // ----------------------------------------

    typedef logic [31:0] word_t;    // Bus data word
    typedef logic [31:0] addr_t;    // Byte address
    typedef logic [3:0]  strb_t;    // One bit per byte lane
    typedef logic [7:0]  byte_t;    // Shared RAM cell and UART character

    // ----------------------------------------
    // Address decode result
    // ----------------------------------------

    // Registered from the look-ahead address one cycle ahead of the access
    typedef enum logic [2:0] {
        REGION_NONE,    // Unmapped, answered by the default responder
        REGION_RAM,
        REGION_GPIO,
        REGION_UART,
        REGION_SHRAM
    } region_e;

endpackage

// ==== src/soc_bus_if.sv ====
// Request/response link between the address decoder and one slave
interface soc_bus_if;

    logic        valid;     // Request for this slave, held until ready
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;     // Nonzero means write
    logic [31:0] rdata;     // Valid while ready is high
    logic        ready;

    modport decoder (
        output valid,
        output addr,
        output wdata,
        output wstrb,
        input  rdata,
        input  ready
    );

    modport slave (
        input  valid,
        input  addr,
        input  wdata,
        input  wstrb,
        output rdata,
        output ready
    );

endinterface

// ==== src/word_ram.sv ====
module word_ram #(
    parameter type word_type = soc_pkg::word_t,
    parameter int  depth     = 2048
) (
    input  logic       clk_rv,
    soc_bus_if.slave   bus
);

    localparam int WIDTH  = $bits(word_type);
    localparam int LANES  = (WIDTH + 7) / 8;    // Byte lanes, at most four
    localparam int IDX_W  = $clog2(depth);

    word_type         mem [depth];
    word_type         rd_q;
    logic [IDX_W-1:0] idx;
    logic             ready_q;

    // Word index above the byte offset, wraps at depth so the RAM echoes
    assign idx = bus.addr[2 +: IDX_W];

    always_ff @(posedge clk_rv) begin
        if (bus.valid) begin
            for (int i = 0; i < LANES; i++) begin
                if (bus.wstrb[i])
                    mem[idx][i*8 +: 8] <= bus.wdata[i*8 +: 8];
            end
            rd_q <= mem[idx];   // Old contents on a write cycle
        end
    end

    // Valid is already dropped by the decoder in the ready cycle
    always_ff @(posedge clk_rv) begin
        ready_q <= bus.valid && !ready_q;
    end

    assign bus.ready = ready_q;
    assign bus.rdata = soc_pkg::word_t'(rd_q);  // Narrow words read zero-extended

endmodule

// ==== src/gpio_regs.sv ====
module gpio_regs (
    input  logic     clk_rv,
    input  logic     rst_rv,
    input  logic     i2c_sda_in,
    soc_bus_if.slave bus,
    output logic     led_red_n,
    output logic     led_green_n,
    output logic     z80_rst,
    output logic     usb_rst_n,
    output logic     i2c_scl,
    output logic     i2c_sda_oe
);

    logic           led_green_q;
    logic           led_red_q;
    logic           z80_rst_q;
    logic           scl_q;
    logic           sda_q;
    logic           usb_rst_n_q;
    logic           ready_q;
    soc_pkg::word_t rdata_q;
    logic [3:0]     idx;

    assign idx = bus.addr[5:2];     // Word index in the window

    // ----------------------------------------
    // Register writes
    // ----------------------------------------

    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            led_green_q <= 1'b0;
            led_red_q   <= 1'b0;
            z80_rst_q   <= 1'b1;    // Z80 held in reset until released
            scl_q       <= 1'b1;
            sda_q       <= 1'b1;    // Bus released
            usb_rst_n_q <= 1'b1;
            ready_q     <= 1'b0;
        end else begin
            ready_q <= bus.valid && !ready_q;
            if (bus.valid && bus.wstrb != '0) begin
                case (idx)
                    4'd1:    led_green_q <= bus.wdata[0];
                    4'd2:    led_red_q   <= bus.wdata[0];
                    4'd3:    z80_rst_q   <= bus.wdata[0];
                    4'd5:    scl_q       <= bus.wdata[0];
                    4'd6:    sda_q       <= bus.wdata[0];
                    4'd7:    usb_rst_n_q <= bus.wdata[0];
                    default: ;
                endcase
            end
        end
    end

    // Readback, only two registers are visible
    always_ff @(posedge clk_rv) begin
        if (bus.valid && bus.wstrb == '0) begin
            case (idx)
                4'd3:    rdata_q <= soc_pkg::word_t'(z80_rst_q);
                4'd6:    rdata_q <= soc_pkg::word_t'(i2c_sda_in);    // Live pin level
                default: rdata_q <= '0;
            endcase
        end
    end

    assign bus.ready   = ready_q;
    assign bus.rdata   = rdata_q;

    assign led_green_n = !led_green_q;  // LEDs are active low
    assign led_red_n   = !led_red_q;
    assign z80_rst     = z80_rst_q;
    assign usb_rst_n   = usb_rst_n_q;
    assign i2c_scl     = scl_q;
    assign i2c_sda_oe  = !sda_q;        // Open drain, pull low when the bit is 0

endmodule

// ==== src/uart_tx.sv ====
`include "soc_config.svh"

module uart_tx (
    input  logic     clk_rv,
    input  logic     rst_rv,
    soc_bus_if.slave bus,
    output logic     uart_txd
);

    localparam int BIT_CYCLES = `SOC_UART_BIT_CYCLES;
    localparam int CYC_W      = (BIT_CYCLES > 1) ? $clog2(BIT_CYCLES) : 1;

    logic [9:0]       shift_q;      // Stop, data LSB first, start
    logic [3:0]       bits_left;
    logic [CYC_W-1:0] cyc_cnt;      // Clocks left in the current bit
    logic             ready_q;
    logic             busy;
    logic             accept;

    assign busy   = (bits_left != 4'd0);
    assign accept = bus.valid && !busy && !ready_q;   // Holds the bus while a frame runs

    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            shift_q   <= '1;        // Line idles high
            bits_left <= 4'd0;
            cyc_cnt   <= '0;
            ready_q   <= 1'b0;
        end else begin
            ready_q <= accept;
            if (accept && bus.wstrb != '0) begin
                shift_q   <= {1'b1, bus.wdata[7:0], 1'b0};
                bits_left <= 4'd10;
                cyc_cnt   <= CYC_W'(BIT_CYCLES - 1);
            end else if (busy) begin
                if (cyc_cnt == '0) begin
                    shift_q   <= {1'b1, shift_q[9:1]};    // Fill with idle level
                    bits_left <= bits_left - 4'd1;
                    cyc_cnt   <= CYC_W'(BIT_CYCLES - 1);
                end else begin
                    cyc_cnt <= cyc_cnt - CYC_W'(1);
                end
            end
        end
    end

    assign uart_txd  = shift_q[0];
    assign bus.ready = ready_q;
    assign bus.rdata = '0;          // Write-only, reads return zero

endmodule

// ==== src/bus_decoder.sv ====
`include "soc_config.svh"

module bus_decoder (
    input  logic           clk_rv,
    input  logic           rst_rv,
    input  logic           mem_valid,
    input  soc_pkg::addr_t mem_la_addr,
    input  soc_pkg::addr_t mem_addr,
    input  soc_pkg::word_t mem_wdata,
    input  soc_pkg::strb_t mem_wstrb,
    output soc_pkg::word_t mem_rdata,
    output logic           mem_ready,
    output logic           irq,
    soc_bus_if.decoder     ram_bus,
    soc_bus_if.decoder     shram_bus,
    soc_bus_if.decoder     gpio_bus,
    soc_bus_if.decoder     uart_bus
);

    soc_pkg::region_e la_region;    // Decode of the look-ahead address
    soc_pkg::region_e region_q;     // Region of the access now on the bus
    logic             default_valid;
    logic             default_ready;
    logic             valid_q;      // mem_valid one cycle late, for edge detect

    // ----------------------------------------
    // Look-ahead decode
    // ----------------------------------------

    always_comb begin
        if (mem_la_addr >= `SOC_RAM_BASE)
            la_region = soc_pkg::REGION_RAM;
        else if (mem_la_addr >= `SOC_GPIO_BASE && mem_la_addr < `SOC_GPIO_LIMIT)
            la_region = soc_pkg::REGION_GPIO;
        else if (mem_la_addr == `SOC_UART_ADDR)
            la_region = soc_pkg::REGION_UART;
        else if (mem_la_addr >= `SOC_SHRAM_BASE && mem_la_addr < `SOC_SHRAM_LIMIT)
            la_region = soc_pkg::REGION_SHRAM;
        else
            la_region = soc_pkg::REGION_NONE;
    end

    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            region_q <= soc_pkg::REGION_NONE;
        end else begin
            region_q <= la_region;  // Every clock, master holds la_addr steady
        end
    end

    // ----------------------------------------
    // Request steering
    // ----------------------------------------

    // One-cycle slaves drop their valid in the ready cycle so they act once
    assign ram_bus.valid   = mem_valid && !mem_ready && (region_q == soc_pkg::REGION_RAM);
    assign shram_bus.valid = mem_valid && !mem_ready && (region_q == soc_pkg::REGION_SHRAM);
    assign gpio_bus.valid  = mem_valid && !mem_ready && (region_q == soc_pkg::REGION_GPIO);
    assign uart_bus.valid  = mem_valid && (region_q == soc_pkg::REGION_UART); // UART paces itself
    assign default_valid   = mem_valid && !mem_ready && (region_q == soc_pkg::REGION_NONE);

    assign ram_bus.addr    = mem_addr;
    assign ram_bus.wdata   = mem_wdata;
    assign ram_bus.wstrb   = mem_wstrb;
    assign shram_bus.addr  = mem_addr;
    assign shram_bus.wdata = mem_wdata;
    assign shram_bus.wstrb = mem_wstrb;
    assign gpio_bus.addr   = mem_addr;
    assign gpio_bus.wdata  = mem_wdata;
    assign gpio_bus.wstrb  = mem_wstrb;
    assign uart_bus.addr   = mem_addr;
    assign uart_bus.wdata  = mem_wdata;
    assign uart_bus.wstrb  = mem_wstrb;

    // ----------------------------------------
    // Default responder and bus fault
    // ----------------------------------------

    always_ff @(posedge clk_rv) begin
        if (!rst_rv) begin
            default_ready <= 1'b0;
            valid_q       <= 1'b0;
            irq           <= 1'b0;
        end else begin
            default_ready <= default_valid;
            valid_q       <= mem_valid;
            // Sticky until reset
            if (mem_valid && !valid_q && region_q == soc_pkg::REGION_NONE)
                irq <= 1'b1;
        end
    end

    // ----------------------------------------
    // Response merge
    // ----------------------------------------

    assign mem_ready = ram_bus.ready || shram_bus.ready || gpio_bus.ready
                       || uart_bus.ready || default_ready;

    always_comb begin
        case (region_q)
            soc_pkg::REGION_RAM:   mem_rdata = ram_bus.rdata;
            soc_pkg::REGION_SHRAM: mem_rdata = shram_bus.rdata;
            soc_pkg::REGION_GPIO:  mem_rdata = gpio_bus.rdata;
            soc_pkg::REGION_UART:  mem_rdata = uart_bus.rdata;
            default:               mem_rdata = `SOC_UNMAPPED_RDATA;
        endcase
    end

endmodule

// ==== src/soc_top.sv ====
`include "soc_config.svh"

module soc_top (
    input  logic           clk_rv,
    input  logic           rst_rv,
    input  logic           mem_valid,
    input  soc_pkg::addr_t mem_la_addr,
    input  soc_pkg::addr_t mem_addr,
    input  soc_pkg::word_t mem_wdata,
    input  soc_pkg::strb_t mem_wstrb,
    input  logic           i2c_sda_in,
    output soc_pkg::word_t mem_rdata,
    output logic           mem_ready,
    output logic           irq,
    output logic           led_red_n,
    output logic           led_green_n,
    output logic           z80_rst,
    output logic           usb_rst_n,
    output logic           i2c_scl,
    output logic           i2c_sda_oe,
    output logic           uart_txd
);

    soc_bus_if ram_bus ();
    soc_bus_if shram_bus ();
    soc_bus_if gpio_bus ();
    soc_bus_if uart_bus ();

    // ----------------------------------------
    // Decode
    // ----------------------------------------

    bus_decoder u_decoder (
        .clk_rv      (clk_rv),
        .rst_rv      (rst_rv),
        .mem_valid   (mem_valid),
        .mem_la_addr (mem_la_addr),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_wstrb   (mem_wstrb),
        .mem_rdata   (mem_rdata),
        .mem_ready   (mem_ready),
        .irq         (irq),
        .ram_bus     (ram_bus.decoder),
        .shram_bus   (shram_bus.decoder),
        .gpio_bus    (gpio_bus.decoder),
        .uart_bus    (uart_bus.decoder)
    );

    // ----------------------------------------
    // Slaves
    // ----------------------------------------

    word_ram #(
        .word_type (soc_pkg::word_t),
        .depth     (`SOC_RAM_WORDS)
    ) u_ram (
        .clk_rv (clk_rv),
        .bus    (ram_bus.slave)
    );

    // Byte cells, strobe bit 0 only
    word_ram #(
        .word_type (soc_pkg::byte_t),
        .depth     (`SOC_SHRAM_WORDS)
    ) u_shram (
        .clk_rv (clk_rv),
        .bus    (shram_bus.slave)
    );

    gpio_regs u_gpio (
        .clk_rv      (clk_rv),
        .rst_rv      (rst_rv),
        .i2c_sda_in  (i2c_sda_in),
        .bus         (gpio_bus.slave),
        .led_red_n   (led_red_n),
        .led_green_n (led_green_n),
        .z80_rst     (z80_rst),
        .usb_rst_n   (usb_rst_n),
        .i2c_scl     (i2c_scl),
        .i2c_sda_oe  (i2c_sda_oe)
    );

    uart_tx u_uart (
        .clk_rv   (clk_rv),
        .rst_rv   (rst_rv),
        .bus      (uart_bus.slave),
        .uart_txd (uart_txd)
    );

endmodule

// ==== tb/soc_checker.sv ====
`include "soc_config.svh"

module soc_checker (
    input  logic           clk_rv,
    input  logic           rst_rv,
    input  logic           mem_valid,
    input  soc_pkg::addr_t mem_addr,
    input  soc_pkg::word_t mem_wdata,
    input  soc_pkg::strb_t mem_wstrb,
    input  soc_pkg::word_t mem_rdata,
    input  logic           mem_ready,
    input  logic           irq,
    input  logic [5:0]     pins,            // red_n, green_n, z80_rst, usb_rst_n, scl, sda_oe
    input  logic           uart_txd,
    input  logic           exp_is_read,
    input  soc_pkg::word_t exp_rdata,
    input  logic [5:0]     exp_pins,
    input  logic           exp_irq,
    output int             value_errs,
    output int             protocol_errs,
    output int             frame_errs,
    output int             uart_pending
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int BIT_CYCLES  = `SOC_UART_BIT_CYCLES;
    localparam int READY_LIMIT = 11 * BIT_CYCLES + 8;   // Longest UART stall plus margin

    logic [7:0] exp_bytes [64];     // Bytes written to the UART, in order
    int         uart_writes;
    int         frames_done;
    int         wait_cycles;
    int         exp_wait;           // Cycles from valid to ready for the current request
    int         cycle_no;           // Clock edges seen so far
    int         uart_free;          // Edge at which a held UART request sees ready
    logic       is_uart;

    assign uart_pending = uart_writes - frames_done;
    assign is_uart      = (mem_addr == `SOC_UART_ADDR);

    function automatic string pin_name(input int i);
        case (i)
            5:       return "led_red_n";
            4:       return "led_green_n";
            3:       return "z80_rst";
            2:       return "usb_rst_n";
            1:       return "i2c_scl";
            default: return "i2c_sda_oe";
        endcase
    endfunction

    task automatic show_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        $display("ERROR %s expected %h actual %h at %0t", name, exp, act, $time);
    endtask

    // ----------------------------------------
    // Bus responses
    // ----------------------------------------

    always @(posedge clk_rv) begin
        cycle_no = cycle_no + 1;
        if (!rst_rv) begin
            wait_cycles = 0;
        end else if (mem_valid && !mem_ready) begin
            // A busy UART holds the request until its frame has left the line
            if (wait_cycles == 0)
                exp_wait = (is_uart && uart_free - cycle_no > 1) ? uart_free - cycle_no : 1;
            wait_cycles = wait_cycles + 1;
            if (wait_cycles == READY_LIMIT) begin
                $display("No ready for address %h after %0d cycles", mem_addr, READY_LIMIT);
                protocol_errs = protocol_errs + 1;
            end
        end else if (mem_valid && mem_ready) begin
            if (wait_cycles != exp_wait) begin
                $display("Ready for address %h came after %0d cycles instead of %0d",
                         mem_addr, wait_cycles, exp_wait);
                protocol_errs = protocol_errs + 1;
            end
            if (exp_is_read && mem_rdata !== exp_rdata) begin
                show_mismatch("mem_rdata", exp_rdata, mem_rdata);
                value_errs = value_errs + 1;
            end
            if (irq !== exp_irq) begin
                show_mismatch("irq", 32'(exp_irq), 32'(irq));
                value_errs = value_errs + 1;
            end
            for (int i = 0; i < 6; i++) begin
                if (pins[i] !== exp_pins[i]) begin
                    show_mismatch(pin_name(i), 32'(exp_pins[i]), 32'(pins[i]));
                    value_errs = value_errs + 1;
                end
            end
            if (is_uart && mem_wstrb != '0) begin
                if (frames_done != uart_writes) begin
                    $display("UART write accepted while the previous frame was still sending");
                    protocol_errs = protocol_errs + 1;
                end
                exp_bytes[uart_writes % 64] = mem_wdata[7:0];
                uart_writes = uart_writes + 1;
                // Ten bits go out, the next byte is taken one cycle after the stop bit
                uart_free = cycle_no + 10 * BIT_CYCLES + 1;
            end
            wait_cycles = 0;
        end else if (mem_ready) begin
            $display("Ready seen at %0t with no request on the bus", $time);
            protocol_errs = protocol_errs + 1;
        end
    end

    // ----------------------------------------
    // Serial frame decode
    // ----------------------------------------

    always begin
        logic [7:0] rx;
        @(posedge clk_rv);
        if (rst_rv && uart_txd === 1'b0) begin
            repeat (BIT_CYCLES + BIT_CYCLES / 2) @(posedge clk_rv);  // Middle of bit 0
            for (int i = 0; i < 8; i++) begin
                rx[i] = uart_txd;               // LSB first
                repeat (BIT_CYCLES) @(posedge clk_rv);
            end
            if (uart_txd !== 1'b1) begin
                $display("UART stop bit missing at %0t", $time);
                frame_errs = frame_errs + 1;
            end else if (frames_done >= uart_writes) begin
                $display("UART frame sent with no write behind it");
                frame_errs = frame_errs + 1;
            end else if (rx !== exp_bytes[frames_done % 64]) begin
                show_mismatch("uart_txd", 32'(exp_bytes[frames_done % 64]), 32'(rx));
                frame_errs = frame_errs + 1;
            end
            frames_done = frames_done + 1;
        end
    end

endmodule

// ==== tb/tb_top.sv ====
`include "soc_config.svh"

module tb_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_RECS     = 64;
    localparam int REC_WORDS    = 8;    // Columns per golden line
    localparam int RESET_CYCLES = 3;
    localparam int UART_WORST   = 11 * `SOC_UART_BIT_CYCLES + 8;

    logic           clk_rv;
    logic           rst_rv;
    logic           mem_valid;
    soc_pkg::addr_t mem_la_addr;
    soc_pkg::addr_t mem_addr;
    soc_pkg::word_t mem_wdata;
    soc_pkg::strb_t mem_wstrb;
    logic           i2c_sda_in;
    soc_pkg::word_t mem_rdata;
    logic           mem_ready;
    logic           irq;
    logic [5:0]     pins;           // red_n, green_n, z80_rst, usb_rst_n, scl, sda_oe
    logic           uart_txd;

    logic           exp_is_read;
    soc_pkg::word_t exp_rdata;
    logic [5:0]     exp_pins;
    logic           exp_irq;
    int             value_errs;
    int             protocol_errs;
    int             frame_errs;
    int             uart_pending;

    logic [31:0]    golden [MAX_RECS * REC_WORDS];
    logic [31:0]    lfsr;
    int             rec_count;
    int             cycle_count;
    int             cycle_limit;

    initial clk_rv = 1'b0;
    always #2 clk_rv = ~clk_rv;     // 4 ns period

    soc_top DUT (
        .clk_rv      (clk_rv),
        .rst_rv      (rst_rv),
        .mem_valid   (mem_valid),
        .mem_la_addr (mem_la_addr),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_wstrb   (mem_wstrb),
        .i2c_sda_in  (i2c_sda_in),
        .mem_rdata   (mem_rdata),
        .mem_ready   (mem_ready),
        .irq         (irq),
        .led_red_n   (pins[5]),
        .led_green_n (pins[4]),
        .z80_rst     (pins[3]),
        .usb_rst_n   (pins[2]),
        .i2c_scl     (pins[1]),
        .i2c_sda_oe  (pins[0]),
        .uart_txd    (uart_txd)
    );

    soc_checker u_checker (
        .clk_rv        (clk_rv),
        .rst_rv        (rst_rv),
        .mem_valid     (mem_valid),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .mem_wstrb     (mem_wstrb),
        .mem_rdata     (mem_rdata),
        .mem_ready     (mem_ready),
        .irq           (irq),
        .pins          (pins),
        .uart_txd      (uart_txd),
        .exp_is_read   (exp_is_read),
        .exp_rdata     (exp_rdata),
        .exp_pins      (exp_pins),
        .exp_irq       (exp_irq),
        .value_errs    (value_errs),
        .protocol_errs (protocol_errs),
        .frame_errs    (frame_errs),
        .uart_pending  (uart_pending)
    );

    // Galois form, taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0])
            return (state >> 1) ^ 32'h8020_0003;
        return state >> 1;
    endfunction

    task automatic idle_gap();
        int gap;
        gap = 1;
        for (int b = 0; b < 2; b++) begin
            gap = gap + (int'(lfsr[0]) << b);
            lfsr = lfsr_step(lfsr);
        end
        repeat (gap) @(posedge clk_rv);
    endtask

    // ----------------------------------------
    // One bus access from the golden table
    // ----------------------------------------

    task automatic run_transaction(input int r);
        int base;
        base = r * REC_WORDS;
        @(posedge clk_rv);
        mem_la_addr <= golden[base + 1];   // Look-ahead one cycle early
        exp_is_read <= (golden[base] == 32'h0);
        exp_rdata   <= golden[base + 4];
        exp_pins    <= golden[base + 5][5:0];
        exp_irq     <= golden[base + 6][0];
        i2c_sda_in  <= golden[base + 7][0];
        @(posedge clk_rv);
        mem_valid <= 1'b1;
        mem_addr  <= golden[base + 1];
        mem_wdata <= golden[base + 2];
        mem_wstrb <= golden[base + 3][3:0];
        do
            @(posedge clk_rv);
        while (mem_ready !== 1'b1);
        mem_valid <= 1'b0;
    endtask

    task automatic print_error_counts();
        $display("Errors: value %0d, protocol %0d, UART frame %0d",
                 value_errs, protocol_errs, frame_errs);
    endtask

    initial begin
        rst_rv      = 1'b0;
        mem_valid   = 1'b0;
        mem_la_addr = '0;
        mem_addr    = '0;
        mem_wdata   = '0;
        mem_wstrb   = '0;
        i2c_sda_in  = 1'b1;
        exp_is_read = 1'b0;
        exp_rdata   = '0;
        exp_pins    = '0;
        exp_irq     = 1'b0;
        lfsr        = 32'ha07d5195;
        $readmemh("tb/soc_golden.txt", golden);
        rec_count = 0;
        while (rec_count < MAX_RECS && golden[rec_count * REC_WORDS] != 32'hF)
            rec_count++;
        cycle_limit = rec_count * UART_WORST + RESET_CYCLES;

        repeat (RESET_CYCLES) @(posedge clk_rv);
        rst_rv <= 1'b1;
        for (int r = 0; r < rec_count; r++) begin
            run_transaction(r);
            idle_gap();
        end
        while (uart_pending > 0)
            @(posedge clk_rv);      // Let the last frame leave the line

        print_error_counts();
        if (value_errs + protocol_errs + frame_errs == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

    always @(posedge clk_rv) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Run stopped after %0d cycles without finishing", cycle_limit);
            print_error_counts();
            $display("Simulation failed");
            $finish;
        end
    end

endmodule

// ==== tb/soc_golden.txt ====
// op (0 read, 1 write, F end)  addr  wdata  strb  rdata  pins  irq  sda_in
// pins = {led_red_n, led_green_n, z80_rst, usb_rst_n, i2c_scl, i2c_sda_oe}
1 FFFF0010 11223344 F 00000000 3E 0 1
1 FFFF0010 AABBCCDD 5 00000000 3E 0 1
0 FFFF0010 00000000 0 11BB33DD 3E 0 1
0 FFFF2010 00000000 0 11BB33DD 3E 0 1
1 FFFF3FFC 01234567 F 00000000 3E 0 1
0 FFFF1FFC 00000000 0 01234567 3E 0 1
1 05000008 12345678 F 00000000 3E 0 1
0 05000008 00000000 0 00000078 3E 0 1
1 0500000C DEADBEEF 1 00000000 3E 0 1
0 0500000C 00000000 0 000000EF 3E 0 1
1 03000004 00000001 F 00000000 2E 0 1
1 03000008 00000001 F 00000000 0E 0 1
1 0300000C 00000000 F 00000000 06 0 1
0 0300000C 00000000 0 00000000 06 0 1
1 03000014 00000000 F 00000000 04 0 1
1 03000018 00000000 F 00000000 05 0 1
1 0300001C 00000000 F 00000000 01 0 1
0 03000018 00000000 0 00000001 01 0 1
0 03000018 00000000 0 00000000 01 0 0
1 0300000C 00000001 F 00000000 09 0 1
0 0300000C 00000000 0 00000001 09 0 1
1 03000018 00000001 F 00000000 08 0 1
1 03000100 000000A5 1 00000000 08 0 1
1 03000100 0000003C 1 00000000 08 0 1
0 03000100 00000000 0 00000000 08 0 1
0 04000000 00000000 0 FFFFFFFF 08 1 1
0 FFFF0010 00000000 0 11BB33DD 08 1 1
1 02000000 00000000 F 00000000 08 1 1
0 03000104 00000000 0 FFFFFFFF 08 1 1
0 0500000C 00000000 0 000000EF 08 1 1
F 00000000 00000000 0 00000000 00 0 0

// ==== sim.f ====
+incdir+src
src/soc_pkg.sv
src/soc_bus_if.sv
src/word_ram.sv
src/gpio_regs.sv
src/uart_tx.sv
src/bus_decoder.sv
src/soc_top.sv
tb/soc_checker.sv
tb/tb_top.sv

// ==== Makefile ====
TOOL       := verilator
FLAGS      := --binary --timing --timescale 1ns/100ps
LINT_FLAGS := --lint-only --timing --timescale 1ns/100ps
TOP        := tb_top
FILELIST   := sim.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
